//--- bicubic_settings.svh
`ifndef BICUBIC_SETTINGS_SVH
`define BICUBIC_SETTINGS_SVH

// Fixed-point widths of the horizontal pass
`define SAMPLE_WIDTH   24
`define PRODUCT_WIDTH  32
`define WEIGHT_WIDTH   12
`define PIXEL_WIDTH    8

`define MULT_LATENCY   2   // Register stages per multiplier, 0 to 2
`define FRAC_SHIFT     22  // Two passes of 2048-scale weights

`endif

//--- bicubic_pkg.sv
`include "bicubic_settings.svh"

package bicubic_pkg;

    // Index into the signed tap weight table
    typedef enum logic [2:0] {
        W_M21   = 3'd0,  // -21
        W_M135  = 3'd1,  // -135
        W_M147  = 3'd2,  // -147
        W_M225  = 3'd3,  // -225
        W_P235  = 3'd4,
        W_P873  = 3'd5,
        W_P1535 = 3'd6,
        W_P1981 = 3'd7
    } weight_code_e;

    typedef enum logic [1:0] {
        PHASE_0,
        PHASE_1,
        PHASE_2,
        PHASE_3
    } phase_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,     // Request held, waiting for run
        RELEASE   // Waiting for req to drop
    } port_state_e;

    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

endpackage

//--- bicubic_req_port.sv
`timescale 1ns/1ps
`include "bicubic_settings.svh"

module bicubic_req_port (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            req,
    input  bicubic_pkg::phase_e             phase,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample0,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample1,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample2,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample3,
    output logic                            ack,
    output logic                            issue,
    output bicubic_pkg::phase_e             held_phase,
    output logic signed [`SAMPLE_WIDTH-1:0] held0,
    output logic signed [`SAMPLE_WIDTH-1:0] held1,
    output logic signed [`SAMPLE_WIDTH-1:0] held2,
    output logic signed [`SAMPLE_WIDTH-1:0] held3
);

    bicubic_pkg::port_state_e state;
    logic                     accept;

    // A stalled issue still needs the held operands, so no new capture then
    assign accept = (state == bicubic_pkg::IDLE) && req && (run || !issue);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= bicubic_pkg::IDLE;
            ack   <= 1'b0;
            issue <= 1'b0;
        end else begin
            if (run) begin
                issue <= 1'b0; // Issue is a one-cycle pulse in run time
            end
            case (state)
                bicubic_pkg::IDLE: begin
                    if (accept) begin
                        if (run) begin
                            issue <= 1'b1;
                            ack   <= 1'b1;
                            state <= bicubic_pkg::RELEASE;
                        end else begin
                            state <= bicubic_pkg::BUSY;
                        end
                    end
                end
                bicubic_pkg::BUSY: begin
                    if (run) begin
                        issue <= 1'b1;
                        ack   <= 1'b1;
                        state <= bicubic_pkg::RELEASE;
                    end
                end
                bicubic_pkg::RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0; // Return-to-zero half of the handshake
                        state <= bicubic_pkg::IDLE;
                    end
                end
                default: state <= bicubic_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_phase <= phase;
            held0      <= sample0;
            held1      <= sample1;
            held2      <= sample2;
            held3      <= sample3;
        end
    end

endmodule

//--- bicubic_tap_select.sv
`timescale 1ns/1ps

module bicubic_tap_select (
    input  bicubic_pkg::phase_e       phase,
    output bicubic_pkg::weight_code_e code0,
    output bicubic_pkg::weight_code_e code1,
    output bicubic_pkg::weight_code_e code2,
    output bicubic_pkg::weight_code_e code3
);

    // Base rows, tap0 first; each sums to 2048
    localparam bicubic_pkg::weight_code_e ROW_NEAR [4] = '{
        bicubic_pkg::W_M147, bicubic_pkg::W_P1981, bicubic_pkg::W_P235, bicubic_pkg::W_M21
    };
    localparam bicubic_pkg::weight_code_e ROW_MID [4] = '{
        bicubic_pkg::W_M135, bicubic_pkg::W_P1535, bicubic_pkg::W_P873, bicubic_pkg::W_M225
    };

    logic                      use_mid;
    logic                      mirror;
    bicubic_pkg::weight_code_e row [4];

    assign use_mid = (phase == bicubic_pkg::PHASE_1) || (phase == bicubic_pkg::PHASE_2);
    assign mirror  = (phase == bicubic_pkg::PHASE_2) || (phase == bicubic_pkg::PHASE_3);

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            row[k] = use_mid ? ROW_MID[k] : ROW_NEAR[k];
        end
    end

    // Phases 2 and 3 read the base rows back to front
    assign code0 = mirror ? row[3] : row[0];
    assign code1 = mirror ? row[2] : row[1];
    assign code2 = mirror ? row[1] : row[2];
    assign code3 = mirror ? row[0] : row[3];

endmodule

//--- bicubic_mult_stage2.sv
`timescale 1ns/1ps
`include "bicubic_settings.svh"

module bicubic_mult_stage2 #(
    parameter int PRODUCT_WIDTH = `PRODUCT_WIDTH
) (
    input  logic                            clk,
    input  logic                            run,
    input  bicubic_pkg::weight_code_e       code,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample,
    output logic signed [PRODUCT_WIDTH-1:0] product
);

    logic signed [`WEIGHT_WIDTH-1:0] weight;
    logic signed [PRODUCT_WIDTH-1:0] mult_data;

    always_comb begin
        case (code)
            bicubic_pkg::W_M21:   weight = -`WEIGHT_WIDTH'sd21;
            bicubic_pkg::W_M135:  weight = -`WEIGHT_WIDTH'sd135;
            bicubic_pkg::W_M147:  weight = -`WEIGHT_WIDTH'sd147;
            bicubic_pkg::W_M225:  weight = -`WEIGHT_WIDTH'sd225;
            bicubic_pkg::W_P235:  weight = `WEIGHT_WIDTH'sd235;
            bicubic_pkg::W_P873:  weight = `WEIGHT_WIDTH'sd873;
            bicubic_pkg::W_P1535: weight = `WEIGHT_WIDTH'sd1535;
            default:              weight = `WEIGHT_WIDTH'sd1981;
        endcase
    end

    // Both operands are signed, so they extend to the product width
    assign mult_data = sample * weight;

    generate
        if (`MULT_LATENCY == 0) begin : g_comb
            assign product = mult_data;
        end else begin : g_pipe
            logic signed [PRODUCT_WIDTH-1:0] pipe [`MULT_LATENCY];

            always_ff @(posedge clk) begin
                if (run) begin
                    pipe[0] <= mult_data;
                    for (int i = 1; i < `MULT_LATENCY; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            assign product = pipe[`MULT_LATENCY-1];
        end
    endgenerate

endmodule

//--- bicubic_accumulate.sv
`timescale 1ns/1ps
`include "bicubic_settings.svh"

module bicubic_accumulate (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             run,
    input  logic                             issue,
    input  logic signed [`PRODUCT_WIDTH-1:0] product0,
    input  logic signed [`PRODUCT_WIDTH-1:0] product1,
    input  logic signed [`PRODUCT_WIDTH-1:0] product2,
    input  logic signed [`PRODUCT_WIDTH-1:0] product3,
    output bicubic_pkg::pixel_t              pixel,
    output logic                             pixel_valid
);

    localparam int SUM_WIDTH = `PRODUCT_WIDTH + 2; // Room for four products
    localparam logic signed [SUM_WIDTH-1:0] ROUND     = SUM_WIDTH'(1) <<< (`FRAC_SHIFT - 1);
    localparam logic signed [SUM_WIDTH-1:0] PIXEL_MAX = SUM_WIDTH'((1 << `PIXEL_WIDTH) - 1);

    logic signed [SUM_WIDTH-1:0] sum;
    logic signed [SUM_WIDTH-1:0] scaled;
    bicubic_pkg::pixel_t         pixel_next;
    logic                        valid_aligned;

    assign sum    = SUM_WIDTH'(product0) + SUM_WIDTH'(product1)
                  + SUM_WIDTH'(product2) + SUM_WIDTH'(product3);
    assign scaled = (sum + ROUND) >>> `FRAC_SHIFT;

    always_comb begin
        if (scaled < 0) begin
            pixel_next = '0;
        end else if (scaled > PIXEL_MAX) begin
            pixel_next = '1;
        end else begin
            pixel_next = scaled[`PIXEL_WIDTH-1:0];
        end
    end

    // Valid travels alongside the multiplier stages
    generate
        if (`MULT_LATENCY == 0) begin : g_no_delay
            assign valid_aligned = issue;
        end else begin : g_delay
            logic [`MULT_LATENCY-1:0] valid_line;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    valid_line <= '0;
                end else if (run) begin
                    valid_line <= (valid_line << 1) | `MULT_LATENCY'(issue);
                end
            end

            assign valid_aligned = valid_line[`MULT_LATENCY-1];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel       <= '0;
            pixel_valid <= 1'b0;
        end else if (run) begin
            pixel_valid <= valid_aligned;
            if (valid_aligned) begin
                pixel <= pixel_next; // Pixel holds the last result between jobs
            end
        end
    end

endmodule

//--- bicubic_stage2_top.sv
`timescale 1ns/1ps
`include "bicubic_settings.svh"

module bicubic_stage2_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            req,
    input  bicubic_pkg::phase_e             phase,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample0,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample1,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample2,
    input  logic signed [`SAMPLE_WIDTH-1:0] sample3,
    output logic                            ack,
    output bicubic_pkg::pixel_t             pixel,
    output logic                            pixel_valid
);

    logic                             issue;
    bicubic_pkg::phase_e              held_phase;
    logic signed [`SAMPLE_WIDTH-1:0]  held0;
    logic signed [`SAMPLE_WIDTH-1:0]  held1;
    logic signed [`SAMPLE_WIDTH-1:0]  held2;
    logic signed [`SAMPLE_WIDTH-1:0]  held3;
    bicubic_pkg::weight_code_e        code0;
    bicubic_pkg::weight_code_e        code1;
    bicubic_pkg::weight_code_e        code2;
    bicubic_pkg::weight_code_e        code3;
    logic signed [`PRODUCT_WIDTH-1:0] product0;
    logic signed [`PRODUCT_WIDTH-1:0] product1;
    logic signed [`PRODUCT_WIDTH-1:0] product2;
    logic signed [`PRODUCT_WIDTH-1:0] product3;

    bicubic_req_port u_req_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .req        (req),
        .phase      (phase),
        .sample0    (sample0),
        .sample1    (sample1),
        .sample2    (sample2),
        .sample3    (sample3),
        .ack        (ack),
        .issue      (issue),
        .held_phase (held_phase),
        .held0      (held0),
        .held1      (held1),
        .held2      (held2),
        .held3      (held3)
    );

    bicubic_tap_select u_tap_select (
        .phase (held_phase),
        .code0 (code0),
        .code1 (code1),
        .code2 (code2),
        .code3 (code3)
    );

    bicubic_mult_stage2 u_mult0 (.clk(clk), .run(run), .code(code0), .sample(held0), .product(product0));
    bicubic_mult_stage2 u_mult1 (.clk(clk), .run(run), .code(code1), .sample(held1), .product(product1));
    bicubic_mult_stage2 u_mult2 (.clk(clk), .run(run), .code(code2), .sample(held2), .product(product2));
    bicubic_mult_stage2 u_mult3 (.clk(clk), .run(run), .code(code3), .sample(held3), .product(product3));

    bicubic_accumulate u_accumulate (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .issue       (issue),
        .product0    (product0),
        .product1    (product1),
        .product2    (product2),
        .product3    (product3),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- bicubic_stage2_properties.sv
`timescale 1ns/1ps
`include "bicubic_settings.svh"

module bicubic_stage2_properties (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic issue,
    input logic pixel_valid
);

    localparam int VALID_WINDOW = `MULT_LATENCY + 1 + 16; // Pipeline depth plus the longest stall

    int fail_count = 0;

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    req_waits_for_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> !$past(ack))
        else begin
            fail_count++;
            $error("req rose while ack was still high");
        end

    issue_gives_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(issue) |-> ##[1:VALID_WINDOW] pixel_valid)
        else begin
            fail_count++;
            $error("issued job produced no pixel_valid");
        end

    reset_clears_outputs: assert property (@(posedge clk)
        !rst_n |=> (!ack && !pixel_valid))
        else begin
            fail_count++;
            $error("ack or pixel_valid high out of reset");
        end

endmodule

bind bicubic_stage2_top bicubic_stage2_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .ack         (ack),
    .issue       (issue),
    .pixel_valid (pixel_valid)
);

//--- bicubic_stage2_tb.sv
`timescale 1ns/1ps
`include "bicubic_settings.svh"

module bicubic_stage2_tb;

    localparam int MAX_PATTERNS = 32;
    localparam int LINE_WORDS   = 7; // Phase, four samples, stall, pixel

    logic                            clk;
    logic                            rst_n;
    logic                            run;
    logic                            req;
    bicubic_pkg::phase_e             phase;
    logic signed [`SAMPLE_WIDTH-1:0] sample0;
    logic signed [`SAMPLE_WIDTH-1:0] sample1;
    logic signed [`SAMPLE_WIDTH-1:0] sample2;
    logic signed [`SAMPLE_WIDTH-1:0] sample3;
    logic                            ack;
    bicubic_pkg::pixel_t             pixel;
    logic                            pixel_valid;

    logic [31:0] pattern_mem [MAX_PATTERNS*LINE_WORDS];
    integer      seed;
    int          pattern_count;
    int          cycle_limit;
    int          cycle_count = 0;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bicubic_stage2_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .req         (req),
        .phase       (phase),
        .sample0     (sample0),
        .sample1     (sample1),
        .sample2     (sample2),
        .sample3     (sample3),
        .ack         (ack),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the patterns did not finish within %0d clock cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int tap_weight(bicubic_pkg::phase_e p, int tap);
        int row [4];
        case (p)
            bicubic_pkg::PHASE_0: row = '{-147, 1981, 235, -21};
            bicubic_pkg::PHASE_1: row = '{-135, 1535, 873, -225};
            bicubic_pkg::PHASE_2: row = '{-225, 873, 1535, -135};
            default:              row = '{-21, 235, 1981, -147};
        endcase
        return row[tap];
    endfunction

    function automatic bicubic_pkg::pixel_t expected_pixel(int base);
        bicubic_pkg::phase_e p;
        longint              sum;
        longint              scaled;
        p   = bicubic_pkg::phase_e'(pattern_mem[base][1:0]);
        sum = 0;
        for (int k = 0; k < 4; k++) begin
            sum += longint'($signed(pattern_mem[base+1+k][`SAMPLE_WIDTH-1:0])) * tap_weight(p, k);
        end
        scaled = (sum + (longint'(1) <<< (`FRAC_SHIFT - 1))) >>> `FRAC_SHIFT;
        if (scaled < 0) begin
            return '0;
        end
        if (scaled > (1 << `PIXEL_WIDTH) - 1) begin
            return '1;
        end
        return bicubic_pkg::pixel_t'(scaled);
    endfunction

    task automatic check_pixel(bicubic_pkg::pixel_t got, bicubic_pkg::pixel_t want, string what);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
            error_count++;
        end
    endtask

    task automatic check_ack(logic got, logic want, string what);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, what, got, want);
            error_count++;
        end
    endtask

    task automatic run_pattern(int index);
        int                  base;
        int                  stall;
        int                  gap;
        int                  stall_start;
        int                  ack_step;
        int                  valid_step;
        int                  errors_before;
        bicubic_pkg::pixel_t model;
        bicubic_pkg::pixel_t last_pixel;
        logic                ack_seen;
        logic                stalled;
        logic                frozen;
        base          = index * LINE_WORDS;
        stall         = int'(pattern_mem[base+5]);
        model         = expected_pixel(base);
        errors_before = error_count;
        if (model !== pattern_mem[base+6][`PIXEL_WIDTH-1:0]) begin
            $display("Pattern %0d lists pixel %0d but the weight table gives %0d",
                     index + 1, pattern_mem[base+6], model);
            error_count++;
        end
        gap         = $unsigned($random(seed)) % 4;
        stall_start = $unsigned($random(seed)) % 4;
        ack_step    = (stall > 0 && stall_start == 0) ? 1 + stall : 1; // Held in BUSY
        valid_step  = 2 + `MULT_LATENCY + stall;
        ack_seen    = 1'b0;
        stalled     = 1'b0;
        last_pixel  = pixel;
        repeat (gap) @(posedge clk);
        for (int step = 0; step <= valid_step + 1; step++) begin
            @(posedge clk);
            if (step == 0) begin
                req     <= 1'b1;
                phase   <= bicubic_pkg::phase_e'(pattern_mem[base][1:0]);
                sample0 <= pattern_mem[base+1][`SAMPLE_WIDTH-1:0];
                sample1 <= pattern_mem[base+2][`SAMPLE_WIDTH-1:0];
                sample2 <= pattern_mem[base+3][`SAMPLE_WIDTH-1:0];
                sample3 <= pattern_mem[base+4][`SAMPLE_WIDTH-1:0];
            end else if (ack_seen) begin
                req <= 1'b0;
            end
            frozen  = stalled; // Run driven last step is seen at this edge
            stalled = (step >= stall_start) && (step < stall_start + stall);
            run    <= !stalled;
            @(negedge clk);
            check_ack(ack, (step == ack_step) || (step == ack_step + 1), "ack");
            check_ack(pixel_valid, step == valid_step, "pixel_valid");
            if (step == valid_step) begin
                check_pixel(pixel, model, "pixel");
            end
            if (frozen) begin
                check_pixel(pixel, last_pixel, "pixel during stall");
            end
            ack_seen   = ack_seen || ack;
            last_pixel = pixel;
        end
        if (error_count == errors_before) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d: phase %0d, stall %0d from step %0d, pixel %0d, %s", index + 1,
                 pattern_mem[base][1:0], stall, stall_start, model,
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int reset_errors;
        seed         = 32'he5d56d2a;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_limit  = 0;
        run          = 1'b1;
        req          = 1'b0;
        phase        = bicubic_pkg::PHASE_0;
        sample0      = '0;
        sample1      = '0;
        sample2      = '0;
        sample3      = '0;
        for (int i = 0; i < MAX_PATTERNS * LINE_WORDS; i++) begin
            pattern_mem[i] = 32'hA500_0000 | 32'(i); // Marks words the file leaves empty
        end
        $readmemh("bicubic_patterns.txt", pattern_mem);
        pattern_count = 0;
        while (pattern_count < MAX_PATTERNS &&
               pattern_mem[pattern_count*LINE_WORDS + LINE_WORDS - 1][31:24] != 8'hA5) begin
            pattern_count++;
        end
        if (pattern_count == 0) begin
            $display("No patterns could be read from bicubic_patterns.txt");
            error_count++;
        end
        cycle_limit = pattern_count * 20 + 50;
        wait (rst_n === 1'b1);
        reset_errors = error_count;
        repeat (4) begin
            @(negedge clk);
            check_ack(ack, 1'b0, "ack after reset");
            check_ack(pixel_valid, 1'b0, "pixel_valid after reset");
            check_pixel(pixel, '0, "pixel after reset");
        end
        if (error_count == reset_errors) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test 0: idle outputs after reset, %s",
                 (error_count == reset_errors) ? "ok" : "mismatch");
        for (int i = 0; i < pattern_count; i++) begin
            run_pattern(i);
        end
        @(negedge clk);
        error_count += dut.u_properties.fail_count;
        $display("Tests ok: %0d, tests with errors: %0d, check errors: %0d, assertion errors: %0d",
                 tests_passed, tests_failed, error_count, dut.u_properties.fail_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- bicubic_patterns.txt
// phase sample0 sample1 sample2 sample3 stall_cycles expected_pixel, all hex
// samples are signed 24-bit first-pass values, 2048 per pixel step
0 032000 032000 032000 032000 0 64
1 012800 012800 012800 012800 0 25
2 064000 064000 064000 064000 2 C8
3 07F800 07F800 07F800 07F800 0 FF
0 005000 019000 02D000 041000 1 39
1 005000 019000 02D000 041000 3 3D
2 005000 019000 02D000 041000 0 4F
3 005000 019000 02D000 041000 1 53
0 0C8000 0C8000 0C8000 0C8000 0 FF
1 FE7000 FE7000 FE7000 FE7000 4 00
0 000000 07D000 07F800 000000 5 FF
2 07F800 000000 000000 07F800 0 00
1 001234 01ABCD 014321 000FFF 2 39
3 FF6000 01E000 028000 032000 1 4D

//--- bicubic_stage2_top.f
+incdir+.
bicubic_pkg.sv
bicubic_req_port.sv
bicubic_tap_select.sv
bicubic_mult_stage2.sv
bicubic_accumulate.sv
bicubic_stage2_top.sv
tb_clock_gen.sv
bicubic_stage2_properties.sv
bicubic_stage2_tb.sv

//--- Bender.yml
package:
  name: bicubic_stage2

sources:
  - include_dirs:
      - .
    files:
      - bicubic_pkg.sv
      - bicubic_req_port.sv
      - bicubic_tap_select.sv
      - bicubic_mult_stage2.sv
      - bicubic_accumulate.sv
      - bicubic_stage2_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - bicubic_stage2_properties.sv
      - bicubic_stage2_tb.sv
